/* cpu_vram_port.sv */
// One pending CPU access only, a new strobe overwrites it; read data returns 2 cycles after issue
`timescale 1ns/1ns

module cpu_vram_port (
	input logic clk,
	input logic reset,
	input logic cpu_wr,
	input logic cpu_rd,
	input logic misc_wr,
	input vram_bus_pkg::vram_addr_t cpu_addr,
	input vram_bus_pkg::vram_word_t cpu_wdata,
	input vram_bus_pkg::slot_t slot,
	input raster_pkg::fetch_tag_t ret_tag,
	input vram_bus_pkg::vram_word_t ret_data,
	output vram_bus_pkg::cpu_req_t req,
	output vram_bus_pkg::ctrl_reg_t ctrl,
	output vram_bus_pkg::vram_word_t cpu_rdata,
	output logic cpu_rd_done
);

	logic issue; // Pending access goes to the RAM this cycle
	logic rd_issued; // Last issued access was a read
	logic rd_return;

	assign issue = (slot == vram_bus_pkg::slot_cpu) && (req.wr || req.rd);
	assign rd_return = rd_issued && ret_tag.valid && (ret_tag.slot == vram_bus_pkg::slot_cpu);

	always_ff @(posedge clk) begin
		if (reset) begin
			req <= '0;
			rd_issued <= 1'b0;
			cpu_rd_done <= 1'b0;
			ctrl <= '0; // Sound and trackball held in reset
		end else begin
			if (cpu_wr || cpu_rd) begin
				// Write wins if both strobes arrive together
				req <= '{wr: cpu_wr, rd: cpu_rd & ~cpu_wr, addr: cpu_addr, wdata: cpu_wdata};
			end else if (issue) begin
				req <= '0;
			end
			rd_issued <= issue && req.rd;
			cpu_rd_done <= rd_return;
			if (misc_wr)
				ctrl <= cpu_wdata[7:0];
		end
	end

	// Read data register
	always_ff @(posedge clk) begin
		if (rd_return)
			cpu_rdata <= ret_data;
	end

endmodule

/* fetch_latch.sv */
// Steers each returned fetch to its slot's register; cpu returns are left to the CPU port
`timescale 1ns/1ns

module fetch_latch (
	input logic clk,
	input logic reset,
	input vram_bus_pkg::vram_word_t rdata,
	input raster_pkg::fetch_tag_t rtag,
	output vram_bus_pkg::vram_word_t alpha_word,
	output logic alpha_valid,
	output raster_pkg::mo_link_t mo_link,
	output raster_pkg::pf_code_t pf_code
);

	logic take_alpha;

	assign take_alpha = rtag.valid && (rtag.slot == vram_bus_pkg::slot_alpha);

	always_ff @(posedge clk) begin
		if (reset) begin
			alpha_valid <= 1'b0;
			mo_link <= '0;
			pf_code <= '0;
		end else begin
			alpha_valid <= take_alpha; // One pulse per alpha fetch
			if (rtag.valid && (rtag.slot == vram_bus_pkg::slot_motion))
				mo_link <= rdata[5:0]; // Next link in the motion chain
			if (rtag.valid && (rtag.slot == vram_bus_pkg::slot_pf))
				pf_code <= '{hflip: rdata[15], pp18: rdata[14], pp_hi: rdata[5:0]};
		end
	end

	// Alpha character word
	always_ff @(posedge clk) begin
		if (take_alpha)
			alpha_word <= rdata;
	end

endmodule

/* pf_vscroll.sv */
// Playfield vertical scroll, load has priority over the line step and the count wraps at 512
`timescale 1ns/1ns

module pf_vscroll (
	input logic clk,
	input logic reset,
	input logic vscroll_ld,
	input raster_pkg::scroll_t load_value,
	input logic hsync_pulse,
	input logic vblank_n,
	output raster_pkg::pf_row_t pf_row,
	output logic [2:0] pp_fine
);

	raster_pkg::scroll_t count;
	logic step;

	// Only visible lines advance the scroll
	assign step = hsync_pulse && vblank_n;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (vscroll_ld) begin
			count <= load_value;
		end else if (step) begin
			count <= count + 1'b1; // Natural 9-bit wrap
		end
	end

	// Row selects the tile, fine bits go to the picture pipe
	assign pf_row = count[8:3];
	assign pp_fine = count[2:0];

endmodule

/* raster_pkg.sv */
// Raster, scroll and fetch result types; the fetch tag needs vram_bus_pkg compiled first
package raster_pkg;

	localparam int raster_w = 8;
	localparam int scroll_w = 9;
	localparam int fine_w = 3; // Scroll bits below the tile row
	localparam int tile_w = 6;

	typedef logic [raster_w-1:0] raster_t; // Line or column count
	typedef logic [scroll_w-1:0] scroll_t;
	typedef logic [scroll_w-fine_w-1:0] pf_row_t; // Scroll bits 8 to 3
	typedef logic [tile_w-1:0] pf_col_t;
	typedef logic [tile_w-1:0] mo_link_t;

	// Playfield tile code as latched from the fetched word
	typedef struct packed {
		logic hflip; // Word bit 15
		logic pp18; // Word bit 14
		logic [tile_w-1:0] pp_hi; // Word bits 5 to 0
	} pf_code_t;

	// Rides along with each RAM read so the result finds its owner
	typedef struct packed {
		logic valid;
		vram_bus_pkg::slot_t slot;
	} fetch_tag_t;

endpackage

/* tb_video_ram.sv */
// Run from the project root so the trace file is found; RAM words are undefined until written
`timescale 1ns/1ns

module tb_video_ram;

	logic clk;
	logic reset;
	logic cpu_wr;
	logic cpu_rd;
	vram_bus_pkg::vram_addr_t cpu_addr;
	vram_bus_pkg::vram_word_t cpu_wdata;
	logic misc_wr;
	logic vscroll_ld;
	vram_bus_pkg::slot_t slot;
	raster_pkg::raster_t v_count;
	raster_pkg::raster_t h_count;
	raster_pkg::pf_col_t pf_col;
	logic mo_4hdl;
	logic h01_n;
	logic hsync_pulse;
	logic vblank_n;
	vram_bus_pkg::vram_word_t cpu_rdata;
	logic cpu_rd_done;
	vram_bus_pkg::ctrl_reg_t ctrl;
	vram_bus_pkg::vram_word_t alpha_word;
	logic alpha_valid;
	raster_pkg::mo_link_t mo_link;
	raster_pkg::pf_code_t pf_code;
	raster_pkg::pf_row_t pf_row;
	logic [2:0] pp_fine;

	int checks;
	int mismatches;
	int timeouts;
	int bad_lines;
	logic [15:0] lfsr_state;
	logic [7:0] ctrl_model; // Expected DUT state, used to build fetch addresses
	logic [8:0] scroll_model;
	logic [5:0] link_model;

	video_ram_top dut0 (
		.clk(clk), .reset(reset), .cpu_wr(cpu_wr), .cpu_rd(cpu_rd), .cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata), .misc_wr(misc_wr), .vscroll_ld(vscroll_ld), .slot(slot),
		.v_count(v_count), .h_count(h_count), .pf_col(pf_col), .mo_4hdl(mo_4hdl),
		.h01_n(h01_n), .hsync_pulse(hsync_pulse), .vblank_n(vblank_n),
		.cpu_rdata(cpu_rdata), .cpu_rd_done(cpu_rd_done), .ctrl(ctrl),
		.alpha_word(alpha_word), .alpha_valid(alpha_valid), .mo_link(mo_link),
		.pf_code(pf_code), .pf_row(pf_row), .pp_fine(pp_fine)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	task automatic check_value(input logic [15:0] got, input logic [15:0] expected,
			input string what);
		checks++;
		if (got !== expected) begin
			mismatches++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int count, output logic [15:0] value);
		int k;
		value = '0;
		for (k = 0; k < count; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[14:0], lfsr_state[0]};
		end
	endtask

	task automatic apply_reset(input logic [7:0] ctrl_after);
		@(posedge clk);
		reset <= 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		ctrl_model = '0;
		scroll_model = '0;
		link_model = '0;
		@(negedge clk);
		check_value(ctrl, ctrl_after, "ctrl after reset");
		check_value({pf_row, pp_fine}, 0, "scroll after reset");
		check_value(mo_link, 0, "mo_link after reset");
		check_value(pf_code, 0, "pf_code after reset");
	endtask

	// No slot has fetched yet, so both pulses stay quiet
	task automatic check_idle();
		repeat (4) begin
			@(negedge clk);
			check_value(alpha_valid, 0, "alpha_valid before fetches");
			check_value(cpu_rd_done, 0, "cpu_rd_done before reads");
		end
	endtask

	task automatic cpu_write(input logic [12:0] addr, input logic [15:0] data);
		@(posedge clk);
		cpu_wr <= 1'b1;
		cpu_addr <= addr;
		cpu_wdata <= data;
		@(posedge clk);
		cpu_wr <= 1'b0;
		repeat (2) @(posedge clk); // Issued in the next cpu slot and lands at its end
	endtask

	task automatic cpu_read_check(input logic [12:0] addr, input logic [15:0] expected);
		int n;
		@(posedge clk);
		cpu_rd <= 1'b1;
		cpu_addr <= addr;
		@(posedge clk);
		cpu_rd <= 1'b0;
		n = 0;
		@(negedge clk);
		while (!cpu_rd_done && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (cpu_rd_done) begin
			check_value(cpu_rdata, expected, $sformatf("cpu read of %h", addr));
		end else begin
			timeouts++;
			$display("timeout, cpu_rd_done never came for the read of address %h", addr);
		end
	endtask

	task automatic write_ctrl(input logic [7:0] value, input logic [7:0] expected);
		@(posedge clk);
		misc_wr <= 1'b1;
		cpu_wdata <= {8'h00, value};
		@(posedge clk);
		misc_wr <= 1'b0;
		@(negedge clk);
		check_value(ctrl, expected, "ctrl");
		ctrl_model = expected;
	endtask

	task automatic load_scroll(input logic [8:0] value, input logic [8:0] expected);
		@(posedge clk);
		vscroll_ld <= 1'b1;
		cpu_wdata <= {7'h00, value};
		@(posedge clk);
		vscroll_ld <= 1'b0;
		@(negedge clk);
		check_value({pf_row, pp_fine}, expected, "scroll after load");
		scroll_model = expected;
	endtask

	task automatic send_hsyncs(input logic [15:0] count, input logic level,
			input logic [8:0] expected);
		repeat (count) begin
			@(posedge clk);
			hsync_pulse <= 1'b1;
			vblank_n <= level;
			@(posedge clk);
			hsync_pulse <= 1'b0;
		end
		@(negedge clk);
		check_value({pf_row, pp_fine}, expected, "scroll after hsync pulses");
		scroll_model = expected;
		@(posedge clk);
		vblank_n <= 1'b1;
	endtask

	task automatic fetch_alpha(input logic [7:0] v, input logic [7:0] h,
			input logic [15:0] word);
		int n;
		cpu_write({2'b11, v[7:3], h[7:2]}, word);
		@(posedge clk);
		slot <= vram_bus_pkg::slot_alpha;
		v_count <= v;
		h_count <= h;
		@(posedge clk);
		slot <= vram_bus_pkg::slot_cpu;
		n = 0;
		@(negedge clk);
		while (!alpha_valid && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (alpha_valid) begin
			check_value(alpha_word, word, "alpha_word");
		end else begin
			timeouts++;
			$display("timeout, alpha_valid never came for line %h column %h", v, h);
		end
	endtask

	task automatic fetch_pf(input logic [5:0] col, input logic [15:0] word,
			input logic [7:0] expected);
		cpu_write({1'b0, scroll_model[8:3], col}, word);
		@(posedge clk);
		slot <= vram_bus_pkg::slot_pf;
		pf_col <= col;
		@(posedge clk);
		slot <= vram_bus_pkg::slot_cpu;
		@(posedge clk); // Store then latch
		@(negedge clk);
		check_value(pf_code, expected, "pf_code");
	endtask

	task automatic fetch_motion(input logic [1:0] sel, input logic [15:0] word,
			input logic [5:0] expected);
		cpu_write({2'b10, ctrl_model[5:3], sel[1], sel[0], link_model}, word);
		@(posedge clk);
		slot <= vram_bus_pkg::slot_motion;
		mo_4hdl <= sel[1];
		h01_n <= sel[0];
		@(posedge clk);
		slot <= vram_bus_pkg::slot_cpu;
		@(posedge clk);
		@(negedge clk);
		check_value(mo_link, expected, "mo_link");
		link_model = expected; // Next motion fetch follows the chain
	endtask

	task automatic run_trace(input int fd);
		int n;
		int fields;
		logic [8*120-1:0] line;
		logic [8*8-1:0] op;
		logic [15:0] f1;
		logic [15:0] f2;
		logic [15:0] expected;
		n = $fgets(line, fd);
		while (n != 0) begin
			op = '0;
			fields = $sscanf(line, "%s %h %h %h", op, f1, f2, expected);
			if (fields < 1 || op == "#") begin
				// Comment or blank line
			end else if (fields != 4) begin
				bad_lines++;
				$display("trace line has too few fields and was skipped");
			end else begin
				case (op)
					"w": cpu_write(f1[12:0], f2);
					"r": cpu_read_check(f1[12:0], expected);
					"m": write_ctrl(f1[7:0], expected[7:0]);
					"l": load_scroll(f1[8:0], expected[8:0]);
					"h": send_hsyncs(f1, f2[0], expected[8:0]);
					"x": apply_reset(expected[7:0]);
					"a": fetch_alpha(f1[7:0], f2[7:0], expected);
					"p": fetch_pf(f1[5:0], f2, expected[7:0]);
					"o": fetch_motion(f1[1:0], f2, expected[5:0]);
					default: begin
						bad_lines++;
						$display("trace line has an unknown opcode and was skipped");
					end
				endcase
			end
			n = $fgets(line, fd);
		end
	endtask

	task automatic run_random_rw();
		logic [12:0] addr_list [0:7];
		logic [15:0] word_list [0:7];
		logic [15:0] bits;
		int i;
		for (i = 0; i < 8; i++) begin
			take_bits(10, bits);
			addr_list[i] = {bits[9:0], i[2:0]}; // Low bits keep each address apart
			take_bits(16, bits);
			word_list[i] = bits;
			cpu_write(addr_list[i], word_list[i]);
		end
		for (i = 0; i < 8; i++)
			cpu_read_check(addr_list[i], word_list[i]);
	endtask

	task automatic report_and_finish();
		$display("%0d checks, %0d mismatches, %0d timeouts, %0d bad trace lines",
			checks, mismatches, timeouts, bad_lines);
		if (checks > 0 && mismatches == 0 && timeouts == 0 && bad_lines == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	endtask

	initial begin
		int fd;
		reset = 1'b1;
		cpu_wr = 1'b0;
		cpu_rd = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		misc_wr = 1'b0;
		vscroll_ld = 1'b0;
		slot = vram_bus_pkg::slot_cpu;
		v_count = '0;
		h_count = '0;
		pf_col = '0;
		mo_4hdl = 1'b0;
		h01_n = 1'b0;
		hsync_pulse = 1'b0;
		vblank_n = 1'b1;
		checks = 0;
		mismatches = 0;
		timeouts = 0;
		bad_lines = 0;
		lfsr_state = 16'd7;
		apply_reset(8'h00);
		check_idle();
		fd = $fopen("video_ram_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open video_ram_trace.txt in the working directory");
			$display("Test failed");
			$finish;
		end else begin
			run_trace(fd);
			$fclose(fd);
			run_random_rw();
			report_and_finish();
		end
	end

endmodule

/* video_ram.f */
vram_bus_pkg.sv
raster_pkg.sv
cpu_vram_port.sv
vram_addr_sel.sv
vram_store.sv
pf_vscroll.sv
fetch_latch.sv
video_ram_top.sv
tb_video_ram.sv

/* video_ram_top.sv */
// Video RAM subsystem; slot, raster counts and strobes must come synchronous to clk
`timescale 1ns/1ns

module video_ram_top (
	input logic clk,
	input logic reset,
	input logic cpu_wr,
	input logic cpu_rd,
	input vram_bus_pkg::vram_addr_t cpu_addr,
	input vram_bus_pkg::vram_word_t cpu_wdata,
	input logic misc_wr,
	input logic vscroll_ld,
	input vram_bus_pkg::slot_t slot,
	input raster_pkg::raster_t v_count,
	input raster_pkg::raster_t h_count,
	input raster_pkg::pf_col_t pf_col,
	input logic mo_4hdl,
	input logic h01_n,
	input logic hsync_pulse,
	input logic vblank_n,
	output vram_bus_pkg::vram_word_t cpu_rdata,
	output logic cpu_rd_done,
	output vram_bus_pkg::ctrl_reg_t ctrl,
	output vram_bus_pkg::vram_word_t alpha_word,
	output logic alpha_valid,
	output raster_pkg::mo_link_t mo_link,
	output raster_pkg::pf_code_t pf_code,
	output raster_pkg::pf_row_t pf_row,
	output logic [2:0] pp_fine
);

	vram_bus_pkg::cpu_req_t req;
	vram_bus_pkg::vram_addr_t mem_addr;
	logic mem_we;
	vram_bus_pkg::vram_word_t mem_wdata;
	vram_bus_pkg::vram_word_t mem_rdata;
	raster_pkg::fetch_tag_t iss_tag; // Tag of the access issued this cycle
	raster_pkg::fetch_tag_t ret_tag; // Tag of the word coming back

	cpu_vram_port u_port (
		.clk(clk), .reset(reset), .cpu_wr(cpu_wr), .cpu_rd(cpu_rd), .misc_wr(misc_wr),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .slot(slot), .ret_tag(ret_tag),
		.ret_data(mem_rdata), .req(req), .ctrl(ctrl), .cpu_rdata(cpu_rdata),
		.cpu_rd_done(cpu_rd_done)
	);

	vram_addr_sel u_addr_sel (
		.clk(clk), .reset(reset), .slot(slot), .req(req), .mpbs(ctrl.mpbs),
		.v_count(v_count), .h_count(h_count), .mo_4hdl(mo_4hdl), .h01_n(h01_n),
		.pf_row(pf_row), .pf_col(pf_col), .mo_link(mo_link), .addr(mem_addr),
		.we(mem_we), .wdata(mem_wdata), .tag(iss_tag)
	);

	vram_store u_store (
		.clk(clk), .addr(mem_addr), .we(mem_we), .wdata(mem_wdata), .tag(iss_tag),
		.rdata(mem_rdata), .rtag(ret_tag)
	);

	pf_vscroll u_vscroll (
		.clk(clk), .reset(reset), .vscroll_ld(vscroll_ld), .load_value(cpu_wdata[8:0]),
		.hsync_pulse(hsync_pulse), .vblank_n(vblank_n), .pf_row(pf_row), .pp_fine(pp_fine)
	);

	fetch_latch u_fetch (
		.clk(clk), .reset(reset), .rdata(mem_rdata), .rtag(ret_tag),
		.alpha_word(alpha_word), .alpha_valid(alpha_valid), .mo_link(mo_link),
		.pf_code(pf_code)
	);

endmodule

/* video_ram_trace.txt */
# op f1 f2 expected, hex; w addr data, r addr expected, m byte ctrl, l value scroll, x ctrl
# h pulses vblank_n scroll, a v_count h_count word, p pf_col word code, o {4hdl,h01_n} word link
w 0123 beef 0
r 0123 0 beef
w 1fff 0001 0
w 0000 ffff 0
r 1fff 0 0001
r 0000 0 ffff
w 0456 a5a5 0
w 0456 5a5a 0
r 0456 0 5a5a
m a7 0 a7
m 3c 0 3c
x 0 0 00
m 18 0 18
l 1f0 0 1f0
h 5 1 1f5
h 3 0 1f5
h 0c 1 001
l 02b 0 02b
p 0a 8013 93
p 3f 7fff 7f
p 01 c025 e5
a 40 84 1234
a ff ff 0f0f
o 2 0025 25
o 1 ff1a 1a
o 3 0000 00
o 0 abcd 0d
x 0 0 00
r 0123 0 beef
r 0456 0 5a5a

/* vram_addr_sel.sv */
// Combinational slot address mux; the motion link is frozen at the start of each motion run
`timescale 1ns/1ns

module vram_addr_sel (
	input logic clk,
	input logic reset,
	input vram_bus_pkg::slot_t slot,
	input vram_bus_pkg::cpu_req_t req,
	input vram_bus_pkg::mpbs_t mpbs,
	input raster_pkg::raster_t v_count,
	input raster_pkg::raster_t h_count,
	input logic mo_4hdl,
	input logic h01_n,
	input raster_pkg::pf_row_t pf_row,
	input raster_pkg::pf_col_t pf_col,
	input raster_pkg::mo_link_t mo_link,
	output vram_bus_pkg::vram_addr_t addr,
	output logic we,
	output vram_bus_pkg::vram_word_t wdata,
	output raster_pkg::fetch_tag_t tag
);

	logic in_motion; // Previous cycle was a motion slot
	raster_pkg::mo_link_t link_held;
	raster_pkg::mo_link_t link_use;

	// Fresh link on the first motion cycle, held after that so a returning fetch
	// cannot move the address in the middle of the slot
	assign link_use = in_motion ? link_held : mo_link;

	always_ff @(posedge clk) begin
		if (reset) begin
			in_motion <= 1'b0;
			link_held <= '0;
		end else begin
			in_motion <= (slot == vram_bus_pkg::slot_motion);
			if ((slot == vram_bus_pkg::slot_motion) && !in_motion)
				link_held <= mo_link;
		end
	end

	always_comb begin
		case (slot)
			vram_bus_pkg::slot_alpha: addr = {2'b11, v_count[7:3], h_count[7:2]};
			vram_bus_pkg::slot_motion: addr = {2'b10, mpbs, mo_4hdl, h01_n, link_use};
			vram_bus_pkg::slot_pf: addr = {1'b0, pf_row, pf_col};
			default: addr = req.addr; // CPU slot
		endcase
	end

	assign we = (slot == vram_bus_pkg::slot_cpu) && req.wr;
	assign wdata = req.wdata;
	assign tag.valid = (slot != vram_bus_pkg::slot_cpu) || req.wr || req.rd;
	assign tag.slot = slot;

endmodule

/* vram_bus_pkg.sv */
// CPU side and video RAM bus types; slot codes follow the clock generator's 2-bit order
package vram_bus_pkg;

	localparam int word_w = 16;
	localparam int addr_w = 13;
	localparam int vram_depth = 1 << addr_w; // 8K words

	typedef logic [word_w-1:0] vram_word_t;
	typedef logic [addr_w-1:0] vram_addr_t;
	typedef logic [2:0] mpbs_t; // Motion picture bank select

	// Slot code from the clock generator
	typedef enum logic [1:0] {
		slot_cpu    = 2'd0,
		slot_alpha  = 2'd1,
		slot_motion = 2'd2,
		slot_pf     = 2'd3
	} slot_t;

	typedef struct packed {
		logic snd_reset_n; // Bit 7, low holds sound in reset
		logic tb_test;
		mpbs_t mpbs;
		logic pp19;
		logic tb_reset_n; // Low holds trackball in reset
		logic alpha_bank; // Bit 0
	} ctrl_reg_t;

	typedef struct packed {
		logic wr;
		logic rd;
		vram_addr_t addr;
		vram_word_t wdata;
	} cpu_req_t;

endpackage

/* vram_store.sv */
// 8K x 16 RAM, read-before-write; contents are undefined until written, no reset
`timescale 1ns/1ns

module vram_store (
	input logic clk,
	input vram_bus_pkg::vram_addr_t addr,
	input logic we,
	input vram_bus_pkg::vram_word_t wdata,
	input raster_pkg::fetch_tag_t tag,
	output vram_bus_pkg::vram_word_t rdata,
	output raster_pkg::fetch_tag_t rtag
);

	vram_bus_pkg::vram_word_t mem [0:vram_bus_pkg::vram_depth-1];

	// Registered read; a write cycle returns the old word
	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

	// Tag follows its data by the same one cycle, so back to back
	// fetches from different slots stay matched
	always_ff @(posedge clk) begin
		rtag <= tag;
	end

endmodule
